// File: all.f
logic/spritePkg.sv
logic/regFile.sv
logic/dmaEngine.sv
logic/imageCache.sv
logic/spriteScan.sv
logic/pixelMixer.sv
logic/spriteController.sv
dv/sprite_assertions.sv
dv/spriteTb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run spriteTb"
	@echo "  clean  remove the build directory"

obj_dir/VspriteTb: all.f logic/*.sv dv/*.sv
	verilator --binary --timing --assert --top-module spriteTb -Mdir obj_dir -f all.f

test: obj_dir/VspriteTb
	@out="$$(./obj_dir/VspriteTb 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir

// File: dv/spriteTb.sv
`timescale 1ns/1ps

module spriteTb import spritePkg::*; ();

	logic vclk = 1'b0;
	logic rst_i = 1'b1;
	logic reg_stb_i = 1'b0;
	logic reg_we_i = 1'b0;
	logic [REG_ADDR_W-1:0] reg_adr_i = '0;
	logic [31:0] reg_dat_i = '0;
	logic reg_ack_o;
	logic [31:0] reg_dat_o;
	logic dma_cyc_o;
	logic [31:0] dma_adr_o;
	logic dma_ack_i = 1'b0;
	logic [31:0] dma_dat_i = '0;
	logic hsync_i = 1'b0;
	logic vsync_i = 1'b0;
	logic blank_i = 1'b0;
	logic [31:0] zrgb_i = '0;
	logic [31:0] zrgb_o;
	logic irq_o;

	int seed = 32'he4a8ae62;
	int ackDelay = 0;
	logic [31:0] fetched[$];

	// shadow of the sprite settings
	int hp[4];
	int vp[4];
	int wm[4];
	int hm[4];
	logic [23:0] base[4];
	logic [23:0] tcol[4];
	logic [3:0] enMask;
	logic [3:0] expColl;
	logic [31:0] rd;

	spriteController uut (.*);

	always #5 vclk = ~vclk;

	// --------------------------------------------------
	// checks and memory model
	// --------------------------------------------------

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic timedOut(input string what);
		$display("timed out waiting for %s", what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	// column 3 of every row holds the transparent color
	function automatic logic [31:0] memWord(input logic [31:0] a);
		if (a[4:2] == 3'd3)
			return {8'hEE, 24'h123456};
		return {8'hEE, a[15:8] ^ a[31:24], a[7:0] ^ a[23:16] ^ 8'h3C, 8'h77};
	endfunction

	// system memory answering with a random late ack
	always begin
		@(posedge vclk);
		#1;
		dma_ack_i = 1'b0;
		if (dma_cyc_o) begin
			if (ackDelay == 0) begin
				dma_ack_i = 1'b1;
				dma_dat_i = memWord(dma_adr_o);
				fetched.push_back(dma_adr_o);
				ackDelay = $random(seed) & 3;
			end else
				ackDelay--;
		end
	end

	// --------------------------------------------------
	// register port
	// --------------------------------------------------

	task automatic writeReg(input logic [4:0] adr, input logic [31:0] dat);
		int k;
		reg_stb_i = 1'b1;
		reg_we_i = 1'b1;
		reg_adr_i = adr;
		reg_dat_i = dat;
		@(posedge vclk);
		#1;
		reg_stb_i = 1'b0;
		reg_we_i = 1'b0;
		for (k = 0; k < 4 && !reg_ack_o; k++) begin
			@(posedge vclk);
			#1;
		end
		if (!reg_ack_o)
			timedOut("register write ack");
	endtask

	task automatic readReg(input logic [4:0] adr, output logic [31:0] dat);
		int k;
		reg_stb_i = 1'b1;
		reg_we_i = 1'b0;
		reg_adr_i = adr;
		@(posedge vclk);
		#1;
		reg_stb_i = 1'b0;
		for (k = 0; k < 4 && !reg_ack_o; k++) begin
			@(posedge vclk);
			#1;
		end
		if (!reg_ack_o)
			timedOut("register read ack");
		dat = reg_dat_o;
	endtask

	task automatic writeCheck(input logic [4:0] adr, input logic [31:0] dat);
		logic [31:0] d;
		writeReg(adr, dat);
		readReg(adr, d);
		checkValue($sformatf("reg_dat_o @%0d", adr), d, dat);
	endtask

	// polls the pending mask until every fetch is done
	task automatic waitDmaIdle();
		logic [31:0] d;
		int k;
		d = 32'hFFFF_FFFF;
		for (k = 0; k < 400 && d != 0; k++) begin
			repeat (8) @(posedge vclk);
			#1;
			readReg(DT_SET, d);
		end
		if (d != 0)
			timedOut("DMA triggers to clear");
	endtask

	// expects 64 words of each of two sprites in address order
	task automatic checkFetch(input int first, input int second);
		checkValue("fetch count", 32'(fetched.size()), 32'd128);
		for (int i = 0; i < 128; i++)
			checkValue("dma_adr_o", fetched[i],
				{(i < 64) ? base[first] : base[second], 6'(i % 64), 2'b00});
	endtask

	// --------------------------------------------------
	// pixel reference
	// --------------------------------------------------

	// lowest enabled, covering, opaque sprite wins
	task automatic pixelRef(input int r, input int c, input logic bl, input logic [31:0] zin,
		output logic [31:0] e, output logic [3:0] act);
		logic [31:0] w;
		act = '0;
		e = zin;
		for (int s = 3; s >= 0; s--) begin
			w = memWord({base[s], 6'(((r - vp[s]) * 8) + (c - hp[s])), 2'b00});
			if (enMask[s] && c >= hp[s] && c <= hp[s] + wm[s] && r >= vp[s] &&
				r <= vp[s] + hm[s] && w[23:0] != tcol[s]) begin
				act[s] = 1'b1;
				e = {8'h00, w[23:0]};
			end
		end
		if (bl)
			e = '0;
	endtask

	// drives one 64x24 frame and compares the output three cycles later
	task automatic runFrame(input logic blankAll);
		logic [31:0] expQ[$];
		logic [31:0] e;
		logic [3:0] act;
		int r;
		int c;
		for (int n = 0; n < 64 * 24 + 3; n++) begin
			@(posedge vclk);
			#1;
			if (n >= 3)
				checkValue("zrgb_o", zrgb_o, expQ.pop_front());
			if (n < 64 * 24) begin
				r = n / 64;
				c = n % 64;
				hsync_i = (c < 4);
				vsync_i = (r == 0);
				blank_i = blankAll || c >= 60;
				zrgb_i = $random(seed);
				pixelRef(r, c, blank_i, zrgb_i, e, act);
				expQ.push_back(e);
				if ($countones(act) > 1)
					expColl = expColl | act;
			end else begin
				hsync_i = 1'b0;
				vsync_i = 1'b0;
				blank_i = 1'b0;
			end
		end
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------

	initial begin
		hp = '{10, 14, 30, 33};
		vp = '{2, 5, 10, 12};
		wm = '{7, 5, 7, 4};
		hm = '{7, 3, 7, 6};
		base = '{24'h001000, 24'h002340, 24'h0A5A00, 24'h7F0011};
		tcol = '{24'h123456, 24'h123456, 24'h123456, 24'h0};
		// sprite 3 hides its first pixel instead of column 3
		tcol[3] = 24'(memWord({base[3], 8'h00}));
		repeat (16) @(posedge vclk);
		#1;
		rst_i = 1'b0;

		// register readback and setup
		for (int s = 0; s < 4; s++) begin
			writeCheck(5'(s * 4) + POS, {4'h0, 12'(vp[s]), 4'h0, 12'(hp[s])});
			writeCheck(5'(s * 4) + SIZE, {21'h0, 3'(hm[s]), 5'h0, 3'(wm[s])});
			writeCheck(5'(s * 4) + SYSADDR, {base[s], 8'h00});
			writeCheck(5'(s * 4) + TC, {8'h00, tcol[s]});
		end
		enMask = 4'b1011;
		writeCheck(EN, 32'(enMask));

		// fetches go to the lowest pending sprite first
		fetched.delete();
		writeReg(DT_SET, 32'b0101);
		waitDmaIdle();
		checkFetch(0, 2);
		fetched.delete();
		writeReg(DT_SET, 32'b1010);
		waitDmaIdle();
		checkFetch(1, 3);

		// frame with sprite 2 off and the interrupt on
		writeReg(IE, 32'h1);
		writeReg(COLL, 32'h0);
		expColl = '0;
		runFrame(1'b0);
		readReg(COLL, rd);
		checkValue("collMask", rd, 32'(expColl));
		checkValue("irq_o", 32'(irq_o), 32'(|expColl));

		// COLL write clears mask and irq
		writeReg(COLL, 32'h0);
		expColl = '0;
		readReg(COLL, rd);
		checkValue("collMask", rd, 32'h0);
		checkValue("irq_o", 32'(irq_o), 32'h0);

		// blank held high with all sprites on and the interrupt off
		writeReg(IE, 32'h0);
		enMask = 4'hF;
		writeReg(EN, 32'(enMask));
		runFrame(1'b1);
		readReg(COLL, rd);
		checkValue("collMask", rd, 32'(expColl));
		checkValue("irq_o", 32'(irq_o), 32'h0);

		$display("TEST OK");
		$finish;
	end

endmodule

// File: dv/sprite_assertions.sv
`timescale 1ns/1ps

module sprite_assertions (
	input logic        vclk,
	input logic        rst_i,
	input logic        reg_stb_i,
	input logic        reg_ack_o,
	input logic        dma_cyc_o,
	input logic        dma_ack_i,
	input logic [31:0] dma_adr_o,
	input logic        irqEnable_i,
	input logic        irq_o,
	input logic        blank_i,
	input logic [31:0] zrgb_o
);

	// --------------------------------------------------
	// register port
	// --------------------------------------------------

	// ack exactly one cycle after a strobe, never otherwise
	ackAfterStb: assert property (@(posedge vclk) disable iff (rst_i)
		reg_stb_i |=> reg_ack_o) else $error("ack missing after strobe");
	noAckWithoutStb: assert property (@(posedge vclk) disable iff (rst_i)
		!reg_stb_i |=> !reg_ack_o) else $error("ack without strobe");

	// --------------------------------------------------
	// master port
	// --------------------------------------------------

	// address held while the cycle waits for its ack
	adrStable: assert property (@(posedge vclk) disable iff (rst_i)
		dma_cyc_o && !dma_ack_i |=> $stable(dma_adr_o)) else $error("dma address moved");

	// bus idle once reset has been seen
	cycLowAfterReset: assert property (@(posedge vclk)
		rst_i |=> !dma_cyc_o) else $error("dma cycle active after reset");

	// --------------------------------------------------
	// interrupt and video
	// --------------------------------------------------

	// irq only rises when enabled one cycle earlier
	irqNeedsEnable: assert property (@(posedge vclk) disable iff (rst_i)
		$rose(irq_o) |-> $past(irqEnable_i)) else $error("irq rose while disabled");

	// blank input gives black three cycles on
	blankBlack: assert property (@(posedge vclk) disable iff (rst_i)
		blank_i |-> ##3 (zrgb_o == 32'h0)) else $error("blank pixel not black");

endmodule

bind spriteController sprite_assertions uChecks (
	.vclk(vclk), .rst_i(rst_i),
	.reg_stb_i(reg_stb_i), .reg_ack_o(reg_ack_o),
	.dma_cyc_o(dma_cyc_o), .dma_ack_i(dma_ack_i), .dma_adr_o(dma_adr_o),
	.irqEnable_i(irqEnable), .irq_o(irq_o),
	.blank_i(blank_i), .zrgb_o(zrgb_o)
);

// File: logic/spriteController.sv
`timescale 1ns/1ps

module spriteController import spritePkg::*; (
	input  logic                  vclk,
	input  logic                  rst_i,
	// register slave
	input  logic                  reg_stb_i,
	input  logic                  reg_we_i,
	input  logic [REG_ADDR_W-1:0] reg_adr_i,
	input  logic [31:0]           reg_dat_i,
	output logic                  reg_ack_o,
	output logic [31:0]           reg_dat_o,
	// DMA master
	output logic                  dma_cyc_o,
	output logic [31:0]           dma_adr_o,
	input  logic                  dma_ack_i,
	input  logic [31:0]           dma_dat_i,
	// video
	input  logic                  hsync_i,
	input  logic                  vsync_i,
	input  logic                  blank_i,
	input  logic [31:0]           zrgb_i,
	output logic [31:0]           zrgb_o,
	output logic                  irq_o
);

	spriteCfg_t [NUM_SPRITES-1:0] cfg;
	logic [NUM_SPRITES-1:0] enable;
	logic [NUM_SPRITES-1:0] trigger;
	logic [NUM_SPRITES-1:0] collMask;
	logic irqEnable;
	logic collClear;
	logic dmaDone;
	logic [SPR_IDX_W-1:0] dmaOwner;
	logic [NUM_SPRITES-1:0] cacheWe;
	logic [CACHE_ADDR_W-1:0] cacheAdr;
	logic [31:0] cacheDat;
	logic [NUM_SPRITES-1:0][CACHE_ADDR_W-1:0] rdAdr;
	logic [NUM_SPRITES-1:0][31:0] pixel;
	logic [NUM_SPRITES-1:0] spriteDe;

	regFile uRegFile (
		.vclk(vclk), .rst_i(rst_i),
		.reg_stb_i(reg_stb_i), .reg_we_i(reg_we_i),
		.reg_adr_i(reg_adr_i), .reg_dat_i(reg_dat_i),
		.dmaDone_i(dmaDone), .dmaOwner_i(dmaOwner), .collMask_i(collMask),
		.reg_ack_o(reg_ack_o), .reg_dat_o(reg_dat_o),
		.cfg_o(cfg), .enable_o(enable), .trigger_o(trigger),
		.irqEnable_o(irqEnable), .collClear_o(collClear)
	);

	dmaEngine uDma (
		.vclk(vclk), .rst_i(rst_i),
		.trigger_i(trigger), .cfg_i(cfg),
		.dma_ack_i(dma_ack_i), .dma_dat_i(dma_dat_i),
		.dma_cyc_o(dma_cyc_o), .dma_adr_o(dma_adr_o),
		.cacheWe_o(cacheWe), .cacheAdr_o(cacheAdr), .cacheDat_o(cacheDat),
		.dmaDone_o(dmaDone), .dmaOwner_o(dmaOwner)
	);

	// one image cache per sprite, all on the shared write bus
	for (genvar g = 0; g < NUM_SPRITES; g++) begin : gCache
		imageCache uCache (
			.vclk(vclk), .we_i(cacheWe[g]),
			.wrAdr_i(cacheAdr), .wrDat_i(cacheDat),
			.rdAdr_i(rdAdr[g]), .rdDat_o(pixel[g])
		);
	end

	spriteScan uScan (
		.vclk(vclk), .rst_i(rst_i),
		.hsync_i(hsync_i), .vsync_i(vsync_i), .cfg_i(cfg),
		.rdAdr_o(rdAdr), .spriteDe_o(spriteDe)
	);

	pixelMixer uMixer (
		.vclk(vclk), .rst_i(rst_i),
		.zrgb_i(zrgb_i), .blank_i(blank_i),
		.spriteDe_i(spriteDe), .pixel_i(pixel), .cfg_i(cfg), .enable_i(enable),
		.irqEnable_i(irqEnable), .collClear_i(collClear),
		.zrgb_o(zrgb_o), .irq_o(irq_o), .collMask_o(collMask)
	);

endmodule

// File: logic/pixelMixer.sv
`timescale 1ns/1ps

module pixelMixer import spritePkg::*; (
	input  logic                             vclk,
	input  logic                             rst_i,
	input  logic [31:0]                      zrgb_i,
	input  logic                             blank_i,
	input  logic [NUM_SPRITES-1:0]           spriteDe_i,
	input  logic [NUM_SPRITES-1:0][31:0]     pixel_i,
	input  spriteCfg_t [NUM_SPRITES-1:0]     cfg_i,
	input  logic [NUM_SPRITES-1:0]           enable_i,
	input  logic                             irqEnable_i,
	input  logic                             collClear_i,
	output logic [31:0]                      zrgb_o,
	output logic                             irq_o,
	output logic [NUM_SPRITES-1:0]           collMask_o
);

	logic [PIXEL_LATENCY-2:0][31:0] zrgbPipe;
	logic [PIXEL_LATENCY-2:0] blankPipe;
	logic [NUM_SPRITES-1:0] active;
	logic [SPR_IDX_W-1:0] winner;
	logic multiHit;
	logic [NUM_SPRITES-1:0] coll;

	// video in delayed to meet the cache data
	always_ff @(posedge vclk) begin
		zrgbPipe[0] <= zrgb_i;
		blankPipe[0] <= blank_i;
		for (int k = 1; k < PIXEL_LATENCY - 1; k++) begin
			zrgbPipe[k] <= zrgbPipe[k-1];
			blankPipe[k] <= blankPipe[k-1];
		end
	end

	// --------------------------------------------------
	// active mask and priority
	// --------------------------------------------------

	// enabled, inside the window, and not the transparent color
	always_comb begin
		for (int i = 0; i < NUM_SPRITES; i++) begin
			active[i] = enable_i[i] & spriteDe_i[i] & (pixel_i[i][23:0] != cfg_i[i].tc);
		end
	end

	// lowest index on top
	always_comb begin
		winner = '0;
		for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
			if (active[i])
				winner = SPR_IDX_W'(i);
		end
	end

	// more than one bit set
	assign multiHit = |(active & (active - 1'b1));

	// blank forces black, else sprite, else pass through
	always_ff @(posedge vclk) begin
		if (blankPipe[PIXEL_LATENCY-2])
			zrgb_o <= '0;
		else if (|active)
			zrgb_o <= {8'h00, pixel_i[winner][23:0]};
		else
			zrgb_o <= zrgbPipe[PIXEL_LATENCY-2];
	end

	// --------------------------------------------------
	// collision register and interrupt
	// --------------------------------------------------

	// accumulates until a COLL write
	// a collision in the clear cycle reloads instead
	always_ff @(posedge vclk) begin
		if (rst_i) begin
			coll <= '0;
			irq_o <= 1'b0;
		end else if (multiHit) begin
			if (coll == '0 || collClear_i) begin
				coll <= active;
				irq_o <= irqEnable_i;
			end else begin
				coll <= coll | active;
			end
		end else if (collClear_i) begin
			coll <= '0;
			irq_o <= 1'b0;
		end
	end

	assign collMask_o = coll;

endmodule

// File: logic/spriteScan.sv
`timescale 1ns/1ps

module spriteScan import spritePkg::*; (
	input  logic                                     vclk,
	input  logic                                     rst_i,
	input  logic                                     hsync_i,
	input  logic                                     vsync_i,
	input  spriteCfg_t [NUM_SPRITES-1:0]             cfg_i,
	output logic [NUM_SPRITES-1:0][CACHE_ADDR_W-1:0] rdAdr_o,
	output logic [NUM_SPRITES-1:0]                   spriteDe_o
);

	logic hsyncD;
	logic vsyncD;
	logic hEdge;
	logic vEdge;
	rasterPos_t pos;
	logic [NUM_SPRITES-1:0][HCNT_W-1:0] hOff;
	logic [NUM_SPRITES-1:0][VCNT_W-1:0] vOff;
	logic [NUM_SPRITES-1:0] inWindow;

	// --------------------------------------------------
	// raster reference
	// --------------------------------------------------

	// rising edges of the syncs
	assign hEdge = hsync_i & ~hsyncD;
	assign vEdge = vsync_i & ~vsyncD;

	// pos holds the position of the previous input cycle
	// the edge cycle itself is column 0
	always_ff @(posedge vclk) begin
		if (rst_i) begin
			hsyncD <= 1'b0;
			vsyncD <= 1'b0;
			pos <= '0;
		end else begin
			hsyncD <= hsync_i;
			vsyncD <= vsync_i;
			if (hEdge)
				pos.hCnt <= '0;
			else
				pos.hCnt <= pos.hCnt + 1'b1;
			// vsync wins over a coincident hsync
			if (vEdge)
				pos.vCnt <= '0;
			else if (hEdge)
				pos.vCnt <= pos.vCnt + 1'b1;
		end
	end

	// --------------------------------------------------
	// per-sprite window and cache address
	// --------------------------------------------------

	// offsets wrap, so anything left of or above the sprite
	// comes out large and fails the compare
	always_comb begin
		for (int i = 0; i < NUM_SPRITES; i++) begin
			hOff[i] = pos.hCnt - cfg_i[i].hPos;
			vOff[i] = pos.vCnt - cfg_i[i].vPos;
			inWindow[i] = (hOff[i] <= HCNT_W'(cfg_i[i].widthM1)) &&
				(vOff[i] <= VCNT_W'(cfg_i[i].heightM1));
			// address only matters inside the window
			rdAdr_o[i] = CACHE_ADDR_W'(vOff[i] * MAX_DIM + hOff[i]);
		end
	end

	// one stage to line up with the registered cache read
	always_ff @(posedge vclk) begin
		if (rst_i)
			spriteDe_o <= '0;
		else
			spriteDe_o <= inWindow;
	end

endmodule

// File: logic/imageCache.sv
`timescale 1ns/1ps

module imageCache import spritePkg::*; (
	input  logic                    vclk,
	input  logic                    we_i,
	input  logic [CACHE_ADDR_W-1:0] wrAdr_i,
	input  logic [31:0]             wrDat_i,
	input  logic [CACHE_ADDR_W-1:0] rdAdr_i,
	output logic [31:0]             rdDat_o
);

	// one word per pixel, row*8 + column
	logic [31:0] mem [CACHE_WORDS];

	// DMA side
	always_ff @(posedge vclk) begin
		if (we_i)
			mem[wrAdr_i] <= wrDat_i;
	end

	// display side, data one cycle after the address
	always_ff @(posedge vclk) begin
		rdDat_o <= mem[rdAdr_i];
	end

endmodule

// File: logic/dmaEngine.sv
`timescale 1ns/1ps

module dmaEngine import spritePkg::*; (
	input  logic                         vclk,
	input  logic                         rst_i,
	input  logic [NUM_SPRITES-1:0]       trigger_i,
	input  spriteCfg_t [NUM_SPRITES-1:0] cfg_i,
	input  logic                         dma_ack_i,
	input  logic [31:0]                  dma_dat_i,
	output logic                         dma_cyc_o,
	output logic [31:0]                  dma_adr_o,
	output logic [NUM_SPRITES-1:0]       cacheWe_o,
	output logic [CACHE_ADDR_W-1:0]      cacheAdr_o,
	output logic [31:0]                  cacheDat_o,
	output logic                         dmaDone_o,
	output logic [SPR_IDX_W-1:0]         dmaOwner_o
);

	dmaState_e state;
	logic [SPR_IDX_W-1:0] pick;
	logic [SPR_IDX_W-1:0] owner;
	logic [CACHE_ADDR_W-1:0] wordCnt;
	logic lastWord;
	logic ackTaken;

	// fixed priority, lowest pending index wins
	always_comb begin
		pick = '0;
		for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
			if (trigger_i[i])
				pick = SPR_IDX_W'(i);
		end
	end

	assign lastWord = (wordCnt == CACHE_ADDR_W'(CACHE_WORDS - 1));
	assign ackTaken = (state == WAIT_ACK) && dma_ack_i;

	// done is seen in the same cycle as NEXT so the trigger bit
	// is already clear when IDLE looks again
	assign dmaDone_o = (state == NEXT) && lastWord;
	assign dmaOwner_o = owner;

	// --------------------------------------------------
	// bus master FSM
	// --------------------------------------------------

	always_ff @(posedge vclk) begin
		if (rst_i) begin
			state <= IDLE;
			dma_cyc_o <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (|trigger_i)
						state <= REQ;
				end
				REQ: begin
					dma_cyc_o <= 1'b1;
					state <= WAIT_ACK;
				end
				// cyc held until the ack is sampled
				WAIT_ACK: begin
					if (dma_ack_i) begin
						dma_cyc_o <= 1'b0;
						state <= NEXT;
					end
				end
				NEXT: state <= lastWord ? IDLE : REQ;
				default: state <= IDLE;
			endcase
		end
	end

	// owner, word count and address
	always_ff @(posedge vclk) begin
		case (state)
			IDLE: begin
				owner <= pick;
				wordCnt <= '0;
			end
			// word i sits at sysAddr*256 + 4i
			REQ: dma_adr_o <= {cfg_i[owner].sysAddr, wordCnt, 2'b00};
			NEXT: wordCnt <= wordCnt + 1'b1;
			default: ;
		endcase
	end

	// --------------------------------------------------
	// cache write, one cycle after the ack
	// --------------------------------------------------

	always_ff @(posedge vclk) begin
		if (rst_i)
			cacheWe_o <= '0;
		else
			cacheWe_o <= ackTaken ? (NUM_SPRITES'(1) << owner) : '0;
	end

	always_ff @(posedge vclk) begin
		if (ackTaken) begin
			cacheAdr_o <= wordCnt;
			cacheDat_o <= dma_dat_i;
		end
	end

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps

module regFile import spritePkg::*; (
	input  logic                         vclk,
	input  logic                         rst_i,
	input  logic                         reg_stb_i,
	input  logic                         reg_we_i,
	input  logic [REG_ADDR_W-1:0]        reg_adr_i,
	input  logic [31:0]                  reg_dat_i,
	input  logic                         dmaDone_i,
	input  logic [SPR_IDX_W-1:0]         dmaOwner_i,
	input  logic [NUM_SPRITES-1:0]       collMask_i,
	output logic                         reg_ack_o,
	output logic [31:0]                  reg_dat_o,
	output spriteCfg_t [NUM_SPRITES-1:0] cfg_o,
	output logic [NUM_SPRITES-1:0]       enable_o,
	output logic [NUM_SPRITES-1:0]       trigger_o,
	output logic                         irqEnable_o,
	output logic                         collClear_o
);

	regWrite_t wrReg;
	logic regAck;
	logic regRead;
	spriteCfg_t [NUM_SPRITES-1:0] cfg;
	logic [NUM_SPRITES-1:0] en;
	logic ie;
	logic [NUM_SPRITES-1:0] trig;
	logic [NUM_SPRITES-1:0] trigNext;
	logic [SPR_IDX_W-1:0] sprSel;
	regAddr_e sprOfs;
	regAddr_e globAdr;
	logic [31:0] rdWord;

	// --------------------------------------------------
	// port capture
	// --------------------------------------------------

	// ack follows every strobe by one cycle
	always_ff @(posedge vclk) begin
		if (rst_i) begin
			regAck <= 1'b0;
			regRead <= 1'b0;
			wrReg.stb <= 1'b0;
		end else begin
			regAck <= reg_stb_i;
			regRead <= reg_stb_i & ~reg_we_i;
			wrReg.stb <= reg_stb_i & reg_we_i;
		end
		// address is kept for the read mux as well
		if (reg_stb_i) begin
			wrReg.adr <= reg_adr_i;
			wrReg.dat <= reg_dat_i;
		end
	end

	// bit 4 picks the globals, bits 3:2 the sprite
	assign sprSel = wrReg.adr[3:2];
	assign sprOfs = regAddr_e'(REG_ADDR_W'(wrReg.adr[1:0]));
	assign globAdr = regAddr_e'(wrReg.adr);

	// --------------------------------------------------
	// trigger bits
	// --------------------------------------------------

	// a software set wins over a completing fetch
	always_comb begin
		trigNext = trig;
		if (dmaDone_i)
			trigNext[dmaOwner_i] = 1'b0;
		if (wrReg.stb && wrReg.adr[4] && globAdr == DT_CLR)
			trigNext = trigNext & ~wrReg.dat[NUM_SPRITES-1:0];
		if (wrReg.stb && wrReg.adr[4] && globAdr == DT_SET)
			trigNext = trigNext | wrReg.dat[NUM_SPRITES-1:0];
	end

	// settings, enables and triggers
	always_ff @(posedge vclk) begin
		if (rst_i) begin
			cfg <= '0;
			en <= '1;
			ie <= 1'b0;
			trig <= '0;
		end else begin
			trig <= trigNext;
			if (wrReg.stb && !wrReg.adr[4]) begin
				case (sprOfs)
					POS: begin
						cfg[sprSel].hPos <= wrReg.dat[11:0];
						cfg[sprSel].vPos <= wrReg.dat[27:16];
					end
					SIZE: begin
						cfg[sprSel].widthM1 <= wrReg.dat[2:0];
						cfg[sprSel].heightM1 <= wrReg.dat[10:8];
					end
					SYSADDR: cfg[sprSel].sysAddr <= wrReg.dat[31:8];
					TC: cfg[sprSel].tc <= wrReg.dat[23:0];
					default: ;
				endcase
			end else if (wrReg.stb) begin
				case (globAdr)
					EN: en <= wrReg.dat[NUM_SPRITES-1:0];
					IE: ie <= wrReg.dat[0];
					default: ;
				endcase
			end
		end
	end

	// --------------------------------------------------
	// read mux
	// --------------------------------------------------

	always_comb begin
		rdWord = '0;
		if (!wrReg.adr[4]) begin
			case (sprOfs)
				POS: rdWord = {4'h0, cfg[sprSel].vPos, 4'h0, cfg[sprSel].hPos};
				SIZE: rdWord = {21'h0, cfg[sprSel].heightM1, 5'h0, cfg[sprSel].widthM1};
				SYSADDR: rdWord = {cfg[sprSel].sysAddr, 8'h00};
				TC: rdWord = {8'h00, cfg[sprSel].tc};
				default: rdWord = '0;
			endcase
		end else begin
			case (globAdr)
				EN: rdWord = 32'(en);
				IE: rdWord = 32'(ie);
				COLL: rdWord = 32'(collMask_i);
				// both trigger words return the pending mask
				DT_SET, DT_CLR: rdWord = 32'(trig);
				default: rdWord = '0;
			endcase
		end
	end

	// data only on a read acknowledge
	assign reg_ack_o = regAck;
	assign reg_dat_o = regRead ? rdWord : '0;

	assign cfg_o = cfg;
	assign enable_o = en;
	assign trigger_o = trig;
	assign irqEnable_o = ie;
	// one-cycle pulse on a COLL write
	assign collClear_o = wrReg.stb && wrReg.adr[4] && globAdr == COLL;

endmodule

// File: logic/spritePkg.sv
package spritePkg;

	// --------------------------------------------------
	// sizes
	// --------------------------------------------------

	// four sprites, two index bits
	localparam int NUM_SPRITES = 4;
	localparam int SPR_IDX_W = 2;

	// sprites are at most 8x8, one 32-bit word per pixel
	localparam int MAX_DIM = 8;
	localparam int CACHE_WORDS = 64;
	localparam int CACHE_ADDR_W = 6;

	// raster counters
	localparam int HCNT_W = 12;
	localparam int VCNT_W = 12;

	// register word address width
	localparam int REG_ADDR_W = 5;

	// pixel in to pixel out, in vclk cycles
	localparam int PIXEL_LATENCY = 3;

	// --------------------------------------------------
	// register map, word addresses
	// --------------------------------------------------

	// per-sprite registers repeat at sprite*4 + offset
	// globals start at 16
	typedef enum logic [REG_ADDR_W-1:0] {
		POS     = 5'd0,
		SIZE    = 5'd1,
		SYSADDR = 5'd2,
		TC      = 5'd3,
		EN      = 5'd16,
		IE      = 5'd17,
		COLL    = 5'd18,
		DT_SET  = 5'd19,
		DT_CLR  = 5'd20
	} regAddr_e;

	// bus master sequencing
	typedef enum logic [1:0] {
		IDLE,
		REQ,
		WAIT_ACK,
		NEXT
	} dmaState_e;

	// --------------------------------------------------
	// shared structs
	// --------------------------------------------------

	// settings of one sprite
	typedef struct packed {
		logic [HCNT_W-1:0] hPos;
		logic [VCNT_W-1:0] vPos;
		logic [2:0]        widthM1;
		logic [2:0]        heightM1;
		logic [23:0]       sysAddr;
		logic [23:0]       tc;
	} spriteCfg_t;

	// column and row of the current pixel
	typedef struct packed {
		logic [HCNT_W-1:0] hCnt;
		logic [VCNT_W-1:0] vCnt;
	} rasterPos_t;

	// registered register port write
	typedef struct packed {
		logic                  stb;
		logic [REG_ADDR_W-1:0] adr;
		logic [31:0]           dat;
	} regWrite_t;

endpackage
